// File: sim.f
+incdir+src
src/mmioBusPkg.sv
src/periphPkg.sv
src/mmioGpio.sv
src/mmioAudPcm.sv
src/mmioTimer.sv
src/mmioRespMux.sv
src/mmioSubsystem.sv
dv/tbClockGen.sv
dv/mmioSubsystemTb.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -Wno-fatal --top-module mmioSubsystemTb -f sim.f \
	-Mdir obj_dir -o simv > build.log 2>&1 \
	&& ./obj_dir/simv > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "test failed" sim.log && exit 1 || grep -q "test passed" sim.log || exit 1
exit 0

// File: dv/mmioSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmioConsts.svh"

module mmioSubsystemTb
	import mmioBusPkg::*;
	import periphPkg::*;
();

	localparam mmioAddr_t gpioOutAddr = `GPIO_BASE + `GPIO_OUT_OFS;
	localparam mmioAddr_t gpioDirAddr = `GPIO_BASE + `GPIO_DIR_OFS;
	localparam mmioAddr_t gpioInAddr = `GPIO_BASE + `GPIO_IN_OFS;
	localparam mmioAddr_t audSampleAddr = `AUD_BASE + `AUD_SAMPLE_OFS;
	localparam mmioAddr_t timCountAddr = `TIM_BASE + `TIM_COUNT_OFS;
	localparam mmioAddr_t timCmpAddr = `TIM_BASE + `TIM_CMP_OFS;
	localparam mmioAddr_t timIrqAddr = `TIM_BASE + `TIM_IRQ_OFS;
	// nothing decodes this window
	localparam mmioAddr_t unmappedAddr = 32'h5000_0000;

	logic      clock;
	logic      rst;
	mmioAddr_t mmioAddr;
	mmioOpm_t  mmioOpm;
	mmioData_t mmioWData;
	mmioData_t mmioRData;
	memOk_t    mmioOk;
	gpioPins_t gpioIn;
	gpioPins_t gpioOut;
	gpioPins_t gpioDir;
	logic      audOut;
	logic      timIrq;

	string       testName;
	int          testErrors;
	int          passCount;
	int          failCount;
	logic [15:0] lfsrState;

	tbClockGen i_clockGen (.clock(clock), .rst(rst));

	mmioSubsystem i_dut (
		.clock(clock), .rst(rst),
		.mmioAddr(mmioAddr), .mmioOpm(mmioOpm), .mmioWData(mmioWData),
		.mmioRData(mmioRData), .mmioOk(mmioOk),
		.gpioIn(gpioIn), .gpioOut(gpioOut), .gpioDir(gpioDir),
		.audOut(audOut), .timIrq(timIrq)
	);

	// taps 16,14,13,11
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic takeBits(input int n, output mmioData_t value);
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
	endtask

	task automatic reportProblem(input string msg);
		$display("ERROR %s: %s", testName, msg);
		testErrors++;
	endtask

	task automatic checkData(input string what, input mmioData_t expected,
		input mmioData_t actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s %s: expected %h, actual %h",
				testName, what, expected, actual);
			testErrors++;
		end
	endtask

	task automatic checkOk(input string what, input memOk_t expected, input memOk_t actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s %s: expected %s, actual %s",
				testName, what, expected.name(), actual.name());
			testErrors++;
		end
	endtask

	task automatic checkPins(input string what, input gpioPins_t expected,
		input gpioPins_t actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s %s: expected %h, actual %h",
				testName, what, expected, actual);
			testErrors++;
		end
	endtask

	task automatic checkBit(input string what, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s %s: expected %b, actual %b",
				testName, what, expected, actual);
			testErrors++;
		end
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrors = 0;
	endtask

	task automatic finishTest();
		if (testErrors == 0)
		begin
			$display("%s: ok", testName);
			passCount++;
		end
		else
		begin
			$display("%s: FAILED with %0d errors", testName, testErrors);
			failCount++;
		end
	endtask

	// called on a falling edge, returns on the falling edge that shows the reply
	task automatic awaitReply(output bit answered);
		answered = 1'b0;
		for (int i = 0; i < 16 && !answered; i++)
		begin
			@(negedge clock);
			if (mmioOk == MEM_OK)
				answered = 1'b1;
		end
		if (!answered)
			reportProblem("the peripheral did not answer within 16 cycles");
	endtask

	task automatic busWrite(input mmioAddr_t addr, input mmioData_t data);
		bit answered;
		mmioAddr = addr;
		mmioOpm = OPM_WR_DW;
		mmioWData = data;
		awaitReply(answered);
		mmioOpm = OPM_IDLE;
		@(negedge clock);
	endtask

	task automatic busRead(input mmioAddr_t addr, output mmioData_t data);
		bit answered;
		mmioAddr = addr;
		mmioOpm = OPM_RD_DW;
		awaitReply(answered);
		data = answered ? mmioRData : '0;
		mmioOpm = OPM_IDLE;
		@(negedge clock);
	endtask

	task automatic testReset();
		startTest("reset");
		// rst only moves on falling edges
		@(posedge clock);
		for (int i = 0; i < 20 && rst; i++)
			@(posedge clock);
		if (rst)
			reportProblem("reset was never released");
		@(negedge clock);
		checkOk("status", MEM_READY, mmioOk);
		checkPins("gpioOut", '0, gpioOut);
		checkPins("gpioDir", '0, gpioDir);
		checkBit("audOut", 1'b0, audOut);
		checkBit("timIrq", 1'b0, timIrq);
		finishTest();
	endtask

	task automatic testGpioRegs();
		mmioData_t outWord;
		mmioData_t dirWord;
		mmioData_t rd;
		startTest("gpioRegs");
		busRead(gpioOutAddr, rd);
		checkData("out after reset", '0, rd);
		busRead(gpioDirAddr, rd);
		checkData("dir after reset", '0, rd);
		takeBits(32, outWord);
		takeBits(32, dirWord);
		busWrite(gpioOutAddr, outWord);
		busWrite(gpioDirAddr, dirWord);
		busRead(gpioOutAddr, rd);
		checkData("out readback", outWord, rd);
		busRead(gpioDirAddr, rd);
		checkData("dir readback", dirWord, rd);
		checkPins("gpioOut", outWord, gpioOut);
		checkPins("gpioDir", dirWord, gpioDir);
		finishTest();
	endtask

	task automatic testGpioInput();
		mmioData_t pins;
		mmioData_t rd;
		startTest("gpioInput");
		takeBits(32, pins);
		gpioIn = pins;
		// two synchronizer edges plus a spare one
		repeat (3)
			@(negedge clock);
		busRead(gpioInAddr, rd);
		checkData("input readback", pins, rd);
		finishTest();
	endtask

	// ones over 512 cycles within one of 512 * (s + 32768) / 65536
	task automatic checkDensity(input pcmSample_t s);
		int ones;
		int level;
		busWrite(audSampleAddr, {16'h0, s});
		ones = 0;
		level = s + 32768;
		repeat (512)
		begin
			@(negedge clock);
			if (audOut)
				ones++;
		end
		if (ones * 128 - level > 128 || level - ones * 128 > 128)
		begin
			$display("CHECK FAILED %s ones for sample %0d: expected %0.2f within one, actual %0d",
				testName, s, level / 128.0, ones);
			testErrors++;
		end
	endtask

	task automatic testAudio();
		mmioData_t word;
		mmioData_t rd;
		int        sampleValue;
		startTest("audio");
		takeBits(32, word);
		busWrite(audSampleAddr, word);
		busRead(audSampleAddr, rd);
		// low half taken as a signed number
		sampleValue = pcmSample_t'(word[15:0]);
		checkData("sample readback", sampleValue, rd);
		checkDensity(16'sh8000);
		checkDensity(16'sh0000);
		checkDensity(word[15:0]);
		finishTest();
	endtask

	task automatic testTimer();
		mmioData_t first;
		mmioData_t second;
		mmioData_t rd;
		startTest("timer");
		busRead(timCountAddr, first);
		busRead(timCountAddr, second);
		checkBit("count increases", 1'b1, second > first);
		busRead(timCountAddr, rd);
		busWrite(timCmpAddr, rd + 32'd20);
		for (int i = 0; i < 40 && !timIrq; i++)
			@(negedge clock);
		checkBit("irq raised", 1'b1, timIrq);
		busWrite(timIrqAddr, '0);
		checkBit("irq cleared", 1'b0, timIrq);
		busRead(timIrqAddr, rd);
		checkData("irq readback", '0, rd);
		finishTest();
	endtask

	task automatic testHandshake();
		mmioAddr_t targets[3];
		targets = '{gpioOutAddr, audSampleAddr, timCountAddr};
		startTest("handshake");
		foreach (targets[k])
		begin
			checkOk("idle", MEM_READY, mmioOk);
			mmioAddr = targets[k];
			mmioOpm = OPM_RD_DW;
			@(negedge clock);
			checkOk("one cycle after request", MEM_OK, mmioOk);
			@(negedge clock);
			checkOk("request held", MEM_OK, mmioOk);
			mmioOpm = OPM_IDLE;
			@(negedge clock);
			checkOk("after idle", MEM_READY, mmioOk);
		end
		mmioAddr = unmappedAddr;
		mmioOpm = OPM_RD_DW;
		for (int i = 0; i < 16; i++)
		begin
			@(negedge clock);
			checkOk("unmapped address", MEM_READY, mmioOk);
			checkData("unmapped read data", '0, mmioRData);
		end
		mmioOpm = OPM_IDLE;
		@(negedge clock);
		finishTest();
	endtask

	initial
	begin
		mmioAddr = '0;
		mmioOpm = OPM_IDLE;
		mmioWData = '0;
		gpioIn = '0;
		lfsrState = 16'd47;
		passCount = 0;
		failCount = 0;
		testReset();
		testGpioRegs();
		testGpioInput();
		testAudio();
		testTimer();
		testHandshake();
		$display("tests run %0d, ok %0d, failing %0d",
			passCount + failCount, passCount, failCount);
		if (failCount == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/tbClockGen.sv
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
	parameter int halfPeriod = 10,
	parameter int resetCycles = 8
) (
	output logic clock,
	output logic rst
);

	initial
	begin
		clock = 1'b0;
		forever
			#(halfPeriod) clock = ~clock;
	end

	// reset drops on a falling edge like the other inputs
	initial
	begin
		rst = 1'b1;
		repeat (resetCycles)
			@(posedge clock);
		@(negedge clock);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

// File: src/mmioSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module mmioSubsystem
	import mmioBusPkg::*;
	import periphPkg::*;
(
	input  logic      clock,
	input  logic      rst,
	input  mmioAddr_t mmioAddr,
	input  mmioOpm_t  mmioOpm,
	input  mmioData_t mmioWData,
	output mmioData_t mmioRData,
	output memOk_t    mmioOk,
	input  gpioPins_t gpioIn,
	output gpioPins_t gpioOut,
	output gpioPins_t gpioDir,
	output logic      audOut,
	output logic      timIrq
);

	// per-peripheral replies
	mmioData_t gpioRData;
	mmioData_t audRData;
	mmioData_t timRData;
	memOk_t    gpioOk;
	memOk_t    audOk;
	memOk_t    timOk;

	mmioGpio i_gpio (
		.clock(clock), .rst(rst),
		.mmioAddr(mmioAddr), .mmioOpm(mmioOpm), .mmioWData(mmioWData),
		.gpioIn(gpioIn),
		.mmioRData(gpioRData), .mmioOk(gpioOk),
		.gpioOut(gpioOut), .gpioDir(gpioDir)
	);

	mmioAudPcm i_aud (
		.clock(clock), .rst(rst),
		.mmioAddr(mmioAddr), .mmioOpm(mmioOpm), .mmioWData(mmioWData),
		.mmioRData(audRData), .mmioOk(audOk),
		.audOut(audOut)
	);

	mmioTimer i_tim (
		.clock(clock), .rst(rst),
		.mmioAddr(mmioAddr), .mmioOpm(mmioOpm), .mmioWData(mmioWData),
		.mmioRData(timRData), .mmioOk(timOk),
		.timIrq(timIrq)
	);

	// gpio first, then audio, then timer
	mmioRespMux i_respMux (
		.clock(clock), .rst(rst),
		.gpioRData(gpioRData), .audRData(audRData), .timRData(timRData),
		.gpioOk(gpioOk), .audOk(audOk), .timOk(timOk),
		.mmioRData(mmioRData), .mmioOk(mmioOk)
	);

endmodule

`default_nettype wire

// File: src/mmioRespMux.sv
`timescale 1ns/1ps
`default_nettype none

module mmioRespMux
	import mmioBusPkg::*;
(
	input  logic      clock,
	input  logic      rst,
	input  mmioData_t gpioRData,
	input  mmioData_t audRData,
	input  mmioData_t timRData,
	input  memOk_t    gpioOk,
	input  memOk_t    audOk,
	input  memOk_t    timOk,
	output mmioData_t mmioRData,
	output memOk_t    mmioOk
);

	// first peripheral that answers takes the bus
	always_comb
	begin
		mmioRData = '0;
		mmioOk = MEM_READY;
		if (gpioOk != MEM_READY)
		begin
			mmioRData = gpioRData;
			mmioOk = gpioOk;
		end
		else if (audOk != MEM_READY)
		begin
			mmioRData = audRData;
			mmioOk = audOk;
		end
		else if (timOk != MEM_READY)
		begin
			mmioRData = timRData;
			mmioOk = timOk;
		end
	end

	// address windows never overlap, so replies never collide
	assert property (@(posedge clock) disable iff (rst)
		$countones({gpioOk != MEM_READY, audOk != MEM_READY, timOk != MEM_READY}) <= 1);

endmodule

`default_nettype wire

// File: src/mmioTimer.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmioConsts.svh"

module mmioTimer
	import mmioBusPkg::*;
	import periphPkg::*;
(
	input  logic      clock,
	input  logic      rst,
	input  mmioAddr_t mmioAddr,
	input  mmioOpm_t  mmioOpm,
	input  mmioData_t mmioWData,
	output mmioData_t mmioRData,
	output memOk_t    mmioOk,
	output logic      timIrq
);

	localparam mmioAddr_t winBase = `TIM_BASE;

	logic       winHit;
	logic       isReq;
	logic       firstWrite;
	logic [7:0] regOfs;
	timCount_t  timCount;
	timCount_t  timCmp;

	assign winHit = mmioAddr[31:8] == winBase[31:8];
	assign isReq = winHit && (mmioOpm == OPM_RD_DW || mmioOpm == OPM_WR_DW);
	assign firstWrite = isReq && (mmioOpm == OPM_WR_DW) && (mmioOk == MEM_READY);
	assign regOfs = mmioAddr[7:0];

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			timCount <= '0;
			timCmp <= '1;
			timIrq <= 1'b0;
			mmioOk <= MEM_READY;
		end
		else
		begin
			timCount <= timCount + 1'b1;
			mmioOk <= isReq ? MEM_OK : MEM_READY;
			if (firstWrite && regOfs == `TIM_CMP_OFS)
				timCmp <= mmioWData;
			// a new match wins over a clear in the same cycle
			if (timCount == timCmp)
				timIrq <= 1'b1;
			else if (firstWrite && regOfs == `TIM_IRQ_OFS)
				timIrq <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		case (regOfs)
			`TIM_COUNT_OFS: mmioRData <= timCount;
			`TIM_CMP_OFS:   mmioRData <= timCmp;
			`TIM_IRQ_OFS:   mmioRData <= {31'b0, timIrq};
			default:        mmioRData <= '0;
		endcase
	end

	assert property (@(posedge clock) disable iff (rst)
		1'b1 |=> (timCount == timCount_t'($past(timCount) + 1'b1)));

endmodule

`default_nettype wire

// File: src/mmioAudPcm.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmioConsts.svh"

module mmioAudPcm
	import mmioBusPkg::*;
	import periphPkg::*;
(
	input  logic      clock,
	input  logic      rst,
	input  mmioAddr_t mmioAddr,
	input  mmioOpm_t  mmioOpm,
	input  mmioData_t mmioWData,
	output mmioData_t mmioRData,
	output memOk_t    mmioOk,
	output logic      audOut
);

	localparam mmioAddr_t winBase = `AUD_BASE;

	logic        winHit;
	logic        isReq;
	logic        firstWrite;
	pcmSample_t  sample;
	logic [15:0] acc;
	logic [16:0] accSum;

	assign winHit = mmioAddr[31:8] == winBase[31:8];
	assign isReq = winHit && (mmioOpm == OPM_RD_DW || mmioOpm == OPM_WR_DW);
	assign firstWrite = isReq && (mmioOpm == OPM_WR_DW) && (mmioOk == MEM_READY);

	// sample plus 32768 is the sample with its sign bit flipped
	assign accSum = {1'b0, acc} + {1'b0, ~sample[15], sample[14:0]};

	always_ff @(posedge clock)
	begin
		if (rst)
			sample <= '0;
		else if (firstWrite && mmioAddr[7:0] == `AUD_SAMPLE_OFS)
			sample <= mmioWData[15:0];
	end

	// first-order modulator, carry-out is the pulse stream
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			acc <= '0;
			audOut <= 1'b0;
		end
		else
		begin
			acc <= accSum[15:0];
			audOut <= accSum[16];
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
			mmioOk <= MEM_READY;
		else
			mmioOk <= isReq ? MEM_OK : MEM_READY;
	end

	// sample reads back sign-extended
	always_ff @(posedge clock)
	begin
		if (mmioAddr[7:0] == `AUD_SAMPLE_OFS)
			mmioRData <= {{16{sample[15]}}, sample};
		else
			mmioRData <= '0;
	end

	// output stays quiet while reset is held
	assert property (@(posedge clock) rst |=> !audOut);

endmodule

`default_nettype wire

// File: src/mmioGpio.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmioConsts.svh"

module mmioGpio
	import mmioBusPkg::*;
	import periphPkg::*;
(
	input  logic      clock,
	input  logic      rst,
	input  mmioAddr_t mmioAddr,
	input  mmioOpm_t  mmioOpm,
	input  mmioData_t mmioWData,
	input  gpioPins_t gpioIn,
	output mmioData_t mmioRData,
	output memOk_t    mmioOk,
	output gpioPins_t gpioOut,
	output gpioPins_t gpioDir
);

	localparam mmioAddr_t winBase = `GPIO_BASE;

	logic       winHit;
	logic       isReq;
	logic       firstWrite;
	logic [7:0] regOfs;
	gpioPins_t  inMeta;
	gpioPins_t  inSync;

	assign winHit = mmioAddr[31:8] == winBase[31:8];
	assign isReq = winHit && (mmioOpm == OPM_RD_DW || mmioOpm == OPM_WR_DW);
	// writes land only before the reply goes out
	assign firstWrite = isReq && (mmioOpm == OPM_WR_DW) && (mmioOk == MEM_READY);
	assign regOfs = mmioAddr[7:0];

	// two flops between the pins and readback
	always_ff @(posedge clock)
	begin
		inMeta <= gpioIn;
		inSync <= inMeta;
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			gpioOut <= '0;
			gpioDir <= '0;
		end
		else if (firstWrite)
		begin
			case (regOfs)
				`GPIO_OUT_OFS: gpioOut <= mmioWData;
				`GPIO_DIR_OFS: gpioDir <= mmioWData;
				default: ;
			endcase
		end
	end

	// reply is held as long as the request stays up
	always_ff @(posedge clock)
	begin
		if (rst)
			mmioOk <= MEM_READY;
		else
			mmioOk <= isReq ? MEM_OK : MEM_READY;
	end

	always_ff @(posedge clock)
	begin
		case (regOfs)
			`GPIO_OUT_OFS: mmioRData <= gpioOut;
			`GPIO_DIR_OFS: mmioRData <= gpioDir;
			`GPIO_IN_OFS:  mmioRData <= inSync;
			default:       mmioRData <= '0;
		endcase
	end

	// an idle cycle always ends the reply on the next edge
	assert property (@(posedge clock) disable iff (rst)
		(mmioOpm == OPM_IDLE) |=> (mmioOk != MEM_OK));

endmodule

`default_nettype wire

// File: src/periphPkg.sv
`default_nettype none

package periphPkg;

	// one bit per gpio pin
	typedef logic [31:0] gpioPins_t;

	// pcm sample, two's complement
	typedef logic signed [15:0] pcmSample_t;

	// free-running cycle count
	typedef logic [31:0] timCount_t;

endpackage

`default_nettype wire

// File: src/mmioBusPkg.sv
`default_nettype none

`include "mmioConsts.svh"

package mmioBusPkg;

	// request side of the bus
	typedef logic [`MMIO_ADDR_W-1:0] mmioAddr_t;
	typedef logic [`MMIO_DATA_W-1:0] mmioData_t;

	// operation code, as wide as the L2 side drives it
	typedef logic [4:0] mmioOpm_t;

	localparam mmioOpm_t OPM_IDLE  = 5'h00;
	// read double word
	localparam mmioOpm_t OPM_RD_DW = 5'h0B;
	// write double word
	localparam mmioOpm_t OPM_WR_DW = 5'h13;

	// reply status from each peripheral
	typedef enum logic [1:0] {
		MEM_READY = 2'b00,
		MEM_OK    = 2'b01,
		MEM_HOLD  = 2'b10,
		MEM_FAULT = 2'b11
	} memOk_t;

endpackage

`default_nettype wire

// File: src/mmioConsts.svh
`ifndef MMIO_CONSTS_SVH
`define MMIO_CONSTS_SVH

// bus widths
`define MMIO_ADDR_W 32
`define MMIO_DATA_W 32

// peripheral windows, 256 bytes each, decoded on address bits 31..8
`define GPIO_BASE 32'hA000_E000
`define AUD_BASE  32'hA008_1000
`define TIM_BASE  32'hA000_C000

// gpio registers
`define GPIO_OUT_OFS 8'h00
`define GPIO_DIR_OFS 8'h04
`define GPIO_IN_OFS  8'h08

// audio registers
`define AUD_SAMPLE_OFS 8'h00

// timer registers, a write to the irq register clears the flag
`define TIM_COUNT_OFS 8'h00
`define TIM_CMP_OFS   8'h04
`define TIM_IRQ_OFS   8'h08

`endif
